/* source/bridge_config.svh */
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// sizing of the L1 to wishbone bridge.

// entries in the request queue and in the write data queue.
`define BRIDGE_QUEUE_DEPTH 8

// largest burst in words, a power of two.
// burst_len_t holds this value minus one.
`define BRIDGE_MAX_BURST 8

// word address width.
// byte address bits [1:0] are not carried on the bus.
`define BRIDGE_ADDR_W 30

`endif

/* source/l2_request_pkg.sv */
`default_nettype none

`include "bridge_config.svh"

// cache side request types.
package l2_request_pkg;

    // burst length minus one. 0 means a single word.
    typedef logic [$clog2(`BRIDGE_MAX_BURST)-1:0] burst_len_t;

    // requester tag, echoed on every returned beat.
    typedef logic [3:0] sub_id_t;

    // one queued miss request, 42 bits.
    typedef struct packed {
        logic [`BRIDGE_ADDR_W-1:0] addr;      // word address of the first beat.
        logic [3:0]                be;        // byte enables, only used on writes.
        logic                      rnw;       // 1 for read.
        burst_len_t                burst_len; // words minus one.
        sub_id_t                   sub_id;    // tag for the return path.
    } l2_request_t;

endpackage

`default_nettype wire

/* source/wishbone_pkg.sv */
`default_nettype none

`include "bridge_config.svh"

// wishbone bus side types.
package wishbone_pkg;

    // word address on the bus.
    typedef logic [`BRIDGE_ADDR_W-1:0] wb_adr_t;

    // one bus data word.
    typedef logic [31:0] wb_data_t;

    // byte selects, one per data byte.
    typedef logic [3:0] wb_sel_t;

endpackage

`default_nettype wire

/* source/request_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_config.svh"

// synchronous fifo with a typed payload.
// head entry is shown on data_out whenever valid is high.
module request_queue #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = `BRIDGE_QUEUE_DEPTH
) (
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire logic     push,
    input  payload_t      data_in,
    input  wire logic     pop,
    output payload_t      data_out,
    output logic          valid,
    output logic          full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t             mem [DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic                 do_push;
    logic                 do_pop;

    assign do_push = push & ~full;  // push while full is dropped.
    assign do_pop  = pop & valid;   // pop on empty does nothing.

    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign data_out = mem[rd_ptr];  // oldest entry.

    // storage.
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // pointers wrap at DEPTH so any depth works.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // occupancy.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither.
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/burst_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_config.svh"

// beat counter for the current request.
// the low address bits wrap inside the aligned block of the burst.
module burst_counter
    import wishbone_pkg::*;
    import l2_request_pkg::*;
(
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic clear,     // request popped.
    input  wire logic step,      // beat finished.
    input  wb_adr_t   base_adr,  // address of the first beat.
    input  burst_len_t burst_len,
    output wb_adr_t   beat_adr,
    output logic      last_beat
);

    localparam int CNT_W = $clog2(`BRIDGE_MAX_BURST);

    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] offset;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;              // clear wins over step.
        end else if (step) begin
            count <= count + 1'b1;
        end
    end

    // walk forward from the requested word, modulo the burst size.
    assign offset = base_adr[CNT_W-1:0] + count;

    assign beat_adr[`BRIDGE_ADDR_W-1:CNT_W] = base_adr[`BRIDGE_ADDR_W-1:CNT_W];
    assign beat_adr[CNT_W-1:0] = (base_adr[CNT_W-1:0] & ~burst_len) | (offset & burst_len);

    assign last_beat = (count == burst_len);

endmodule

`default_nettype wire

/* source/wishbone_master_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

// runs one queued request as one wishbone classic cycle.
// read words and errors go back to the cache one cycle after the bus answer.
module wishbone_master_fsm
    import wishbone_pkg::*;
    import l2_request_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  arst_n,
    input  wire logic  req_valid,
    input  l2_request_t req,
    input  wire logic  data_valid,
    input  wb_data_t   wr_word,
    input  wb_adr_t    beat_adr,
    input  wire logic  last_beat,
    output logic       req_pop,
    output logic       data_pop,
    output logic       beat_step,
    output logic       wb_cyc,
    output logic       wb_stb,
    output logic       wb_we,
    output wb_adr_t    wb_adr,
    output wb_sel_t    wb_sel,
    output wb_data_t   wb_dat_w,
    input  wb_data_t   wb_dat_r,
    input  wire logic  wb_ack,
    input  wire logic  wb_err,
    output wb_data_t   rd_data,
    output logic       rd_data_valid,
    output sub_id_t    rd_sub_id,
    output logic       rd_error
);

    typedef enum logic [1:0] {IDLE, BUS, FLUSH, DONE} state_t;

    state_t state;
    state_t next_state;
    logic   in_bus;
    logic   beat_end;

    assign in_bus = (state == BUS);

    // writes hold stb low while the next word is missing.
    assign wb_cyc   = in_bus;
    assign wb_stb   = in_bus & (req.rnw | data_valid);
    assign wb_we    = in_bus & ~req.rnw;
    assign wb_adr   = beat_adr;                       // steps only on a beat end.
    assign wb_sel   = req.rnw ? '1 : req.be;          // full word on reads.
    assign wb_dat_w = wr_word;                        // data queue head.

    assign beat_end = wb_stb & (wb_ack | wb_err);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        req_pop    = 1'b0;
        data_pop   = 1'b0;
        beat_step  = 1'b0;
        case (state)
            IDLE: begin
                // a write also waits for its first word.
                if (req_valid && (req.rnw || data_valid)) begin
                    next_state = BUS;
                end
            end
            BUS: begin
                if (beat_end) begin
                    beat_step = 1'b1;
                    data_pop  = ~req.rnw;             // word is used or discarded.
                    if (last_beat || (wb_err && req.rnw)) begin
                        req_pop    = 1'b1;
                        next_state = DONE;
                    end else if (wb_err) begin
                        next_state = FLUSH;           // unsent write words remain.
                    end
                end
            end
            FLUSH: begin
                // drop the rest of the burst as the words show up.
                if (data_valid) begin
                    data_pop  = 1'b1;
                    beat_step = 1'b1;
                    if (last_beat) begin
                        req_pop    = 1'b1;
                        next_state = DONE;
                    end
                end
            end
            DONE: begin
                next_state = IDLE;                    // one cycle with cyc low.
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // return path control.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_data_valid <= 1'b0;
            rd_error      <= 1'b0;
        end else begin
            rd_data_valid <= beat_end & ((req.rnw & wb_ack) | wb_err);
            rd_error      <= beat_end & wb_err;
        end
    end

    // return path payload, qualified by rd_data_valid.
    always_ff @(posedge clk) begin
        rd_data   <= wb_dat_r;
        rd_sub_id <= req.sub_id;
    end

endmodule

`default_nettype wire

/* source/l1_wishbone_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_config.svh"

// bridge from the L1 miss port to a wishbone classic master.
module l1_wishbone_bridge
    import l2_request_pkg::*;
    import wishbone_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    // cache request side.
    input  wire logic                      request_push,
    input  wire logic [`BRIDGE_ADDR_W-1:0] addr,
    input  wire logic [3:0]                be,
    input  wire logic                      rnw,
    input  burst_len_t                     burst_len,
    input  sub_id_t                        sub_id,
    output logic                           request_full,
    input  wire logic                      wr_data_push,
    input  wb_data_t                       wr_data,
    output logic                           data_full,
    // return side, always accepted.
    output logic                           rd_data_valid,
    output wb_data_t                       rd_data,
    output sub_id_t                        rd_sub_id,
    output logic                           rd_error,
    // wishbone master.
    output logic                           wb_cyc,
    output logic                           wb_stb,
    output logic                           wb_we,
    output wb_adr_t                        wb_adr,
    output wb_sel_t                        wb_sel,
    output wb_data_t                       wb_dat_w,
    input  wb_data_t                       wb_dat_r,
    input  wire logic                      wb_ack,
    input  wire logic                      wb_err
);

    l2_request_t req_in;
    l2_request_t req_head;
    logic        req_valid;
    logic        req_pop;
    wb_data_t    wr_word;
    logic        data_valid;
    logic        data_pop;
    wb_adr_t     beat_adr;
    logic        last_beat;
    logic        beat_step;

    // pack the loose request inputs.
    assign req_in = '{
        addr:      addr,
        be:        be,
        rnw:       rnw,
        burst_len: burst_len,
        sub_id:    sub_id
    };

    request_queue #(
        .payload_t (l2_request_t),
        .DEPTH     (`BRIDGE_QUEUE_DEPTH)
    ) u_req_queue (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (request_push),
        .data_in  (req_in),
        .pop      (req_pop),
        .data_out (req_head),
        .valid    (req_valid),
        .full     (request_full)
    );

    // write words, may run ahead of or behind their request.
    request_queue #(
        .payload_t (wb_data_t),
        .DEPTH     (`BRIDGE_QUEUE_DEPTH)
    ) u_data_queue (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (wr_data_push),
        .data_in  (wr_data),
        .pop      (data_pop),
        .data_out (wr_word),
        .valid    (data_valid),
        .full     (data_full)
    );

    burst_counter u_burst_counter (
        .clk       (clk),
        .arst_n    (arst_n),
        .clear     (req_pop),
        .step      (beat_step),
        .base_adr  (req_head.addr),
        .burst_len (req_head.burst_len),
        .beat_adr  (beat_adr),
        .last_beat (last_beat)
    );

    wishbone_master_fsm u_bus_fsm (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .req           (req_head),
        .data_valid    (data_valid),
        .wr_word       (wr_word),
        .beat_adr      (beat_adr),
        .last_beat     (last_beat),
        .req_pop       (req_pop),
        .data_pop      (data_pop),
        .beat_step     (beat_step),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_sel        (wb_sel),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .wb_err        (wb_err),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid),
        .rd_sub_id     (rd_sub_id),
        .rd_error      (rd_error)
    );

endmodule

`default_nettype wire

/* test/wb_memory_model.sv */
`timescale 1ns/1ps
`default_nettype none

// wishbone classic slave memory for the bridge testbench.
// an unwritten word reads as its address times FILL_MUL.
module wb_memory_model
    import wishbone_pkg::*;
#(
    parameter wb_adr_t  ERR_ADR  = 30'h066,        // answers err, never written.
    parameter wb_data_t FILL_MUL = 32'h0001_0001   // odd multiplier.
) (
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire logic     wb_cyc,
    input  wire logic     wb_stb,
    input  wire logic     wb_we,
    input  wire wb_adr_t  wb_adr,
    input  wire wb_sel_t  wb_sel,
    input  wire wb_data_t wb_dat_w,
    output wb_data_t      wb_dat_r,
    output logic          wb_ack,
    output logic          wb_err
);

    wb_data_t   mem [wb_adr_t];  // written words only.
    integer     seed;
    logic [1:0] delay;           // wait cycles left before the next answer.

    initial seed = 9820;

    function automatic wb_data_t fetch(input wb_adr_t a);
        return mem.exists(a) ? mem[a] : wb_data_t'(a) * FILL_MUL;
    endfunction

    // byte lanes with sel high take the new data.
    function automatic wb_data_t merge(input wb_data_t old_w, input wb_data_t new_w,
                                       input wb_sel_t sel);
        wb_data_t lanes;
        lanes = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_w & ~lanes) | (new_w & lanes);
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack   <= 1'b0;
            wb_err   <= 1'b0;
            wb_dat_r <= '0;
            delay    <= 2'd0;
        end else begin
            wb_ack <= 1'b0;                     // answers last one cycle.
            wb_err <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack && !wb_err) begin
                if (delay != 2'd0) begin
                    delay <= delay - 2'd1;      // wait state.
                end else begin
                    delay <= 2'($random(seed)); // 0 to 3 waits for the next beat.
                    if (wb_adr == ERR_ADR) begin
                        wb_err <= 1'b1;
                    end else begin
                        wb_ack   <= 1'b1;
                        wb_dat_r <= fetch(wb_adr);
                        if (wb_we) begin
                            mem[wb_adr] = merge(fetch(wb_adr), wb_dat_w, wb_sel);
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_l1_wishbone_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_config.svh"

// testbench for the L1 to wishbone bridge.
// transactions come from test/bridge_input.txt.
// the bus side is a memory model.
module tb_l1_wishbone_bridge
    import l2_request_pkg::*;
    import wishbone_pkg::*;
();

    localparam int TIMEOUT = 200;       // cycles without progress.

    logic       clk;
    logic       arst_n;
    logic       request_push;
    wb_adr_t    addr;
    wb_sel_t    be;
    logic       rnw;
    burst_len_t burst_len;
    sub_id_t    sub_id;
    logic       request_full;
    logic       wr_data_push;
    wb_data_t   wr_data;
    logic       data_full;
    logic       rd_data_valid;
    wb_data_t   rd_data;
    sub_id_t    rd_sub_id;
    logic       rd_error;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    wb_adr_t    wb_adr;
    wb_sel_t    wb_sel;
    wb_data_t   wb_dat_w;
    wb_data_t   wb_dat_r;
    logic       wb_ack;
    logic       wb_err;

    wb_adr_t    bus_adr [$];            // one entry per expected beat.
    wb_sel_t    bus_sel [$];
    int         bus_txn [$];            // owning request of each beat.
    wb_data_t   ret_data [$];           // one entry per expected return.
    sub_id_t    ret_id [$];
    logic       ret_err [$];

    int         mismatches = 0;
    int         failures = 0;
    logic       stalled = 1'b0;
    logic       saw_full = 1'b0;
    logic       ret_due = 1'b0;         // bus answered last cycle.
    int         beat_txn;
    int         fd;
    int         n;
    int         i;
    int         txn = 0;
    logic [8*128-1:0] text;
    logic       f_rnw;
    wb_adr_t    f_adr;
    burst_len_t f_len;
    wb_sel_t    f_be;
    sub_id_t    f_sid;
    logic       f_err;
    wb_data_t   word;
    wb_data_t   words [$];

    l1_wishbone_bridge u_l1_wishbone_bridge (
        .clk (clk), .arst_n (arst_n),
        .request_push (request_push), .addr (addr), .be (be), .rnw (rnw),
        .burst_len (burst_len), .sub_id (sub_id), .request_full (request_full),
        .wr_data_push (wr_data_push), .wr_data (wr_data), .data_full (data_full),
        .rd_data_valid (rd_data_valid), .rd_data (rd_data), .rd_sub_id (rd_sub_id),
        .rd_error (rd_error),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_sel (wb_sel), .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r),
        .wb_ack (wb_ack), .wb_err (wb_err)
    );

    wb_memory_model #(.ERR_ADR (30'h066)) u_wb_memory_model (
        .clk (clk), .arst_n (arst_n),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_sel (wb_sel), .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r),
        .wb_ack (wb_ack), .wb_err (wb_err)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;               // 4 ns period.

    // the burst walks its aligned block of len+1 words from the requested word.
    function automatic wb_adr_t wrap_adr(input wb_adr_t base, input burst_len_t len,
                                         input int beat);
        int size;
        int start;
        size  = int'(len) + 1;
        start = int'(base % wb_adr_t'(size));   // position inside the block.
        return base - wb_adr_t'(start) + wb_adr_t'((start + beat) % size);
    endfunction

    task automatic check_read(input wb_data_t exp_data, input sub_id_t exp_id);
        if (rd_data !== exp_data || rd_sub_id !== exp_id) begin
            mismatches++;
            $display("MISMATCH at %0t: read word %h id %h, expected %h id %h",
                     $time, rd_data, rd_sub_id, exp_data, exp_id);
        end
    endtask

    task automatic check_error(input sub_id_t exp_id, input logic exp_err);
        if (rd_error !== exp_err || rd_sub_id !== exp_id) begin
            mismatches++;
            $display("MISMATCH at %0t: rd_error %b id %h, expected %b id %h",
                     $time, rd_error, rd_sub_id, exp_err, exp_id);
        end
    endtask

    task automatic check_bus(input wb_adr_t exp_adr, input wb_sel_t exp_sel);
        if (wb_adr !== exp_adr || wb_sel !== exp_sel) begin
            mismatches++;
            $display("MISMATCH at %0t: beat at %h sel %h, expected %h sel %h",
                     $time, wb_adr, wb_sel, exp_adr, exp_sel);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH at %0t: %s is %b, expected %b",
                     $time, name, actual, expected);
        end
    endtask

    task automatic wait_for_room(input logic for_data);
        int t;
        t = 0;
        while ((for_data ? data_full : request_full) && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (for_data ? data_full : request_full) begin
            failures++;
            stalled = 1'b1;
            $display("stall: %s stayed high for %0d cycles",
                     for_data ? "data_full" : "request_full", TIMEOUT);
        end
    endtask

    // the timeout restarts whenever a beat or a return is seen.
    task automatic wait_for_drain();
        int t;
        int left;
        t = 0;
        left = ret_id.size() + bus_adr.size();
        while (left != 0 && t < TIMEOUT) begin
            @(negedge clk);
            t = (ret_id.size() + bus_adr.size() != left) ? 0 : t + 1;
            left = ret_id.size() + bus_adr.size();
        end
        if (left != 0) begin
            failures++;
            stalled = 1'b1;
            $display("stall: no wb_ack or rd_data_valid for %0d cycles, %0d items still owed",
                     TIMEOUT, left);
        end
    endtask

    // monitor on the falling edge where every output is settled.
    always @(negedge clk) begin
        if (arst_n) begin
            if (request_full) saw_full = 1'b1;
            if (rd_data_valid !== ret_due) begin
                mismatches++;
                $display("MISMATCH at %0t: rd_data_valid %b one cycle after the bus answer",
                         $time, rd_data_valid);
            end
            if (rd_data_valid && ret_id.size() == 0) begin
                failures++;
                $display("return with sub-id %h that no request asked for", rd_sub_id);
            end else if (rd_data_valid) begin
                if (!ret_err[0]) check_read(ret_data[0], ret_id[0]);
                check_error(ret_id[0], ret_err[0]);
                void'(ret_data.pop_front());
                void'(ret_id.pop_front());
                void'(ret_err.pop_front());
            end
            ret_due = wb_stb && ((wb_ack && !wb_we) || wb_err);
            if (wb_cyc && wb_stb && (wb_ack || wb_err) && bus_adr.size() == 0) begin
                failures++;
                $display("bus beat at %h that no request asked for", wb_adr);
            end else if (wb_cyc && wb_stb && (wb_ack || wb_err)) begin
                check_bus(bus_adr[0], bus_sel[0]);
                beat_txn = bus_txn[0];
                void'(bus_adr.pop_front());
                void'(bus_sel.pop_front());
                void'(bus_txn.pop_front());
                while (wb_err && bus_txn.size() != 0 && bus_txn[0] == beat_txn) begin
                    void'(bus_adr.pop_front());     // err ends the request.
                    void'(bus_sel.pop_front());
                    void'(bus_txn.pop_front());
                end
            end
        end
    end

    initial begin
        arst_n       = 1'b0;
        request_push = 1'b0;
        addr         = '0;
        be           = '0;
        rnw          = 1'b0;
        burst_len    = '0;
        sub_id       = '0;
        wr_data_push = 1'b0;
        wr_data      = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        // bus and return flags are low under reset.
        check_flag("wb_cyc", wb_cyc, 1'b0);
        check_flag("wb_stb", wb_stb, 1'b0);
        check_flag("wb_we", wb_we, 1'b0);
        check_flag("rd_data_valid", rd_data_valid, 1'b0);
        check_flag("rd_error", rd_error, 1'b0);
        check_flag("request_full", request_full, 1'b0);
        check_flag("data_full", data_full, 1'b0);
        arst_n = 1'b1;
        fd = $fopen("test/bridge_input.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("cannot open test/bridge_input.txt");
        end else begin
            n = $fgets(text, fd);           // two lines of column notes.
            n = $fgets(text, fd);
            while (!stalled &&
                   $fscanf(fd, "%h %h %h %h %h %h",
                           f_rnw, f_adr, f_len, f_be, f_sid, f_err) == 6) begin
                words.delete();
                for (i = 0; i <= int'(f_len); i++) begin
                    n = $fscanf(fd, "%h", word);
                    words.push_back(word);
                    bus_adr.push_back(wrap_adr(f_adr, f_len, i));
                    bus_sel.push_back(f_rnw ? 4'hf : f_be);   // reads take whole words.
                    bus_txn.push_back(txn);
                    if (f_rnw && !f_err) begin
                        ret_data.push_back(word);
                        ret_id.push_back(f_sid);
                        ret_err.push_back(1'b0);
                    end
                end
                if (f_err) begin
                    ret_data.push_back('0);
                    ret_id.push_back(f_sid);
                    ret_err.push_back(1'b1);
                end
                wait_for_room(1'b0);
                if (!stalled) begin
                    addr         = f_adr;
                    be           = f_be;
                    rnw          = f_rnw;
                    burst_len    = f_len;
                    sub_id       = f_sid;
                    request_push = 1'b1;
                    @(negedge clk);
                    request_push = 1'b0;
                end
                for (i = 0; i < words.size() && !f_rnw && !stalled; i++) begin
                    wait_for_room(1'b1);
                    if (!stalled) begin
                        wr_data      = words[i];
                        wr_data_push = 1'b1;
                        @(negedge clk);
                        wr_data_push = 1'b0;
                    end
                end
                txn++;
            end
            $fclose(fd);
            if (!stalled) wait_for_drain();
            repeat (4) @(negedge clk);      // catch stray returns.
            if (!stalled && !saw_full) begin
                failures++;
                $display("request_full never rose while requests were queued back to back");
            end
            if (!stalled) begin
                // leftover words of the failed write are gone, so the data queue
                // fills after exactly its depth.
                for (i = 0; i < `BRIDGE_QUEUE_DEPTH; i++) begin
                    check_flag("data_full", data_full, 1'b0);
                    wr_data      = wb_data_t'(i);
                    wr_data_push = 1'b1;
                    @(negedge clk);
                end
                wr_data_push = 1'b0;
                check_flag("data_full", data_full, 1'b1);
            end
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+source
source/l2_request_pkg.sv
source/wishbone_pkg.sv
source/request_queue.sv
source/burst_counter.sv
source/wishbone_master_fsm.sv
source/l1_wishbone_bridge.sv
test/wb_memory_model.sv
test/tb_l1_wishbone_bridge.sv

/* Makefile */
TOP := tb_l1_wishbone_bridge

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) -f verilog.f

# the run passes only when the pass line shows up in the simulation output.
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf obj_dir

/* test/bridge_input.txt */
# rnw addr burst_len(words-1) be sub_id expect_err, then burst_len+1 hex words:
# write data on writes, expected read words on reads (unused when expect_err is 1)
1 010 0 0 1 0 00100010
1 022 3 0 2 0 00220022 00230023 00200020 00210021
0 030 0 5 3 0 aabbccdd
1 030 0 0 4 0 00bb00dd
0 041 1 f 5 0 11111111 22222222
1 040 1 0 6 0 22222222 11111111
1 100 0 0 7 0 01000100
1 101 0 0 8 0 01010101
1 102 0 0 9 0 01020102
1 103 0 0 a 0 01030103
1 104 0 0 b 0 01040104
1 105 0 0 c 0 01050105
1 106 0 0 d 0 01060106
1 107 0 0 e 0 01070107
1 108 0 0 f 0 01080108
1 109 0 0 0 0 01090109
0 064 3 f 1 1 5a5a0001 5a5a0002 5a5a0003 5a5a0004
1 064 1 0 2 0 5a5a0001 5a5a0002
1 067 0 0 3 0 00670067
